//--- lane_seq_pkg.sv
`default_nettype none

package lane_seq_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////
    localparam int LANES           = 8;
    localparam int MEM_DEPTH       = 514;    // VRF words per lane
    localparam int MAX_VL_PER_LANE = 256;
    localparam int RD_PORTS        = 3;      // vs1, vs2, vs3

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////
    typedef logic [$clog2(MEM_DEPTH)-1:0]             vrf_addr_t;
    typedef logic [$clog2(LANES*MAX_VL_PER_LANE)-1:0] vl_t;
    typedef logic [$clog2(MAX_VL_PER_LANE)-1:0]       lane_cnt_t;
    typedef logic [$clog2(MAX_VL_PER_LANE):0]         step_cnt_t;  // Extra carry bit
    typedef logic [$clog2(MAX_VL_PER_LANE)-1:0]       vmrf_addr_t;
    typedef logic [1:0]                               width_t;
    typedef logic [3:0]                               bwen_t;
    typedef logic [LANES*4-1:0]                       lane_bwen_t;
    typedef logic [2:0]                               port_sel_t;

    // Element width codes
    localparam width_t WIDTH_BYTE = 2'd0;
    localparam width_t WIDTH_HALF = 2'd1;
    localparam width_t WIDTH_WORD = 2'd2;

    ////////////////////////////////////////
    // Enums
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        NORMAL = 3'd0,
        STORE  = 3'd2,
        LOAD   = 3'd4
    } inst_type_e;

    typedef enum logic [1:0] {
        IDLE,
        NORMAL_MODE,
        READ_MODE,      // Store reads
        LOAD_MODE
    } seq_state_e;

    ////////////////////////////////////////
    // Structs
    ////////////////////////////////////////
    typedef struct packed {
        inst_type_e                 inst_type;
        vl_t                        vl;
        width_t                     sew;
        width_t                     wdata_width;
        lane_cnt_t                  inst_delay;     // Steps from first read to first write
        vrf_addr_t                  waddr_start;
        vrf_addr_t [RD_PORTS-1:0]   raddr_start;
        port_sel_t                  store_data_sel;
        logic                       vector_mask;
    } instr_t;

    typedef struct packed {
        logic [1:0]  op2_sel;
        port_sel_t   op3_sel;
        logic [31:0] x_data;
        logic [4:0]  imm;
        logic [5:0]  opmode;
    } alu_ctrl_t;

endpackage

`default_nettype wire

//--- vrf_addr_counter.sv
`timescale 1ns/1ns
`default_nettype none

module vrf_addr_counter (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         load_i,
    input  lane_seq_pkg::vrf_addr_t     start_addr_i,
    input  wire                         en_i,
    input  lane_seq_pkg::width_t        width_i,
    output lane_seq_pkg::vrf_addr_t     addr_o
);
    import lane_seq_pkg::*;

    vrf_addr_t  addr_q;
    logic [1:0] offset_q;       // Byte position inside the current word
    logic [2:0] step_bytes;
    logic [2:0] offset_sum;

    // Element size in bytes, 1/2/4
    assign step_bytes = 3'd1 << width_i;
    assign offset_sum = {1'b0, offset_q} + step_bytes;

    ////////////////////////////////////////
    // Counter
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_q   <= '0;
            offset_q <= '0;
        end else if (load_i) begin
            addr_q   <= start_addr_i;
            offset_q <= '0;
        end else if (en_i) begin
            offset_q <= offset_sum[1:0];
            if (offset_sum[2]) begin    // Wrapped past the word
                addr_q <= addr_q + vrf_addr_t'(1);
            end
        end
    end

    assign addr_o = addr_q;

    // Width code 3 is not an element size
    a_width_legal : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        en_i |-> (width_i != 2'd3)
    );

endmodule

`default_nettype wire

//--- bwen_gen.sv
`timescale 1ns/1ns
`default_nettype none

module bwen_gen (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         en_i,
    input  lane_seq_pkg::width_t        width_i,
    output lane_seq_pkg::lane_bwen_t    bwen_o
);
    import lane_seq_pkg::*;

    bwen_t      onehot_q;       // Byte rotation
    logic [1:0] toggle_q;       // Halfword rotation
    bwen_t      pattern;

    ////////////////////////////////////////
    // Rotators
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            onehot_q <= 4'b0001;
            toggle_q <= 2'b01;
        end else if (en_i) begin
            onehot_q <= {onehot_q[2:0], onehot_q[3]};
            toggle_q <= {toggle_q[0], toggle_q[1]};
        end else begin
            // Restart for the next write window
            onehot_q <= 4'b0001;
            toggle_q <= 2'b01;
        end
    end

    always_comb begin
        case (width_i)
            WIDTH_BYTE: pattern = onehot_q;
            WIDTH_HALF: pattern = {{2{toggle_q[1]}}, {2{toggle_q[0]}}};
            WIDTH_WORD: pattern = 4'b1111;
            default:    pattern = 4'b0000;
        endcase
    end

    // Same pattern on every lane
    assign bwen_o = en_i ? {LANES{pattern}} : '0;

    a_onehot : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        $onehot(onehot_q) && $onehot(toggle_q)
    );

endmodule

`default_nettype wire

//--- read_valid_gen.sv
`timescale 1ns/1ns
`default_nettype none

module read_valid_gen (
    input  wire                                 clk_i,
    input  wire                                 rst_i,
    input  wire                                 load_i,
    input  lane_seq_pkg::vl_t                   vl_i,
    input  wire                                 shift_i,
    output logic [lane_seq_pkg::LANES-1:0]      valid_o
);
    import lane_seq_pkg::*;

    vl_t remain_q;      // Elements not yet read

    ////////////////////////////////////////
    // Remaining count
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
        end else if (load_i) begin
            remain_q <= vl_i;
        end else if (shift_i) begin
            if (remain_q > vl_t'(LANES)) begin
                remain_q <= remain_q - vl_t'(LANES);
            end else begin
                remain_q <= '0;     // Saturate on the last row
            end
        end
    end

    // Partial last row leaves the upper lanes invalid
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            valid_o[i] = shift_i && (vl_t'(i) < remain_q);
        end
    end

endmodule

`default_nettype wire

//--- seq_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module seq_ctrl (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         start_i,
    output logic                        ready_o,
    input  lane_seq_pkg::instr_t        instr_i,
    input  lane_seq_pkg::alu_ctrl_t     alu_i,
    input  wire                         load_last_i,
    output lane_seq_pkg::instr_t        instr_o,
    output lane_seq_pkg::alu_ctrl_t     alu_o,
    output logic                        raddr_load_o,
    output logic                        raddr_en_o,
    output logic                        waddr_load_o,
    output logic                        waddr_en_o,
    output lane_seq_pkg::width_t        write_width_o,
    output logic                        bwen_en_o,
    output logic                        valid_load_o,
    output logic                        valid_shift_o,
    output logic                        store_data_valid_o,
    output logic                        ready_for_load_o,
    output logic                        load_mode_o,
    output logic                        vmrf_wen_o,
    output lane_seq_pkg::vmrf_addr_t    vmrf_addr_o
);
    import lane_seq_pkg::*;

    seq_state_e state_q, state_d;
    instr_t     instr_q;
    alu_ctrl_t  alu_q;
    step_cnt_t  read_limit_q;   // Rows per lane, vl / LANES rounded up
    step_cnt_t  step_cnt_q;
    step_cnt_t  win_end;
    vmrf_addr_t vmrf_cnt_q;
    logic       pending_q;      // Accepted, state change next cycle
    logic       ready_q;
    logic       accept;
    logic       in_idle, in_normal, in_read, in_load;
    logic       rd_active, wr_window, wr_step;
    logic       last_read, last_write;

    assign accept    = start_i && ready_q;
    assign in_idle   = (state_q == IDLE);
    assign in_normal = (state_q == NORMAL_MODE);
    assign in_read   = (state_q == READ_MODE);
    assign in_load   = (state_q == LOAD_MODE);

    ////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            instr_q      <= instr_i;
            alu_q        <= alu_i;
            read_limit_q <= step_cnt_t'(instr_i.vl >> $clog2(LANES))
                          + step_cnt_t'(|instr_i.vl[$clog2(LANES)-1:0]);
        end
    end

    // Window math stays inside 9 bits, delay + limit is at most 511
    assign win_end    = step_cnt_t'(instr_q.inst_delay) + read_limit_q;
    assign rd_active  = (step_cnt_q < read_limit_q);
    assign wr_window  = (step_cnt_q >= step_cnt_t'(instr_q.inst_delay)) && (step_cnt_q < win_end);
    assign last_read  = ((step_cnt_q + step_cnt_t'(1)) >= read_limit_q);
    assign last_write = ((step_cnt_q + step_cnt_t'(1)) >= win_end);
    assign wr_step    = in_normal && wr_window;

    ////////////////////////////////////////
    // Control registers
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= IDLE;
            pending_q  <= 1'b0;
            ready_q    <= 1'b1;
            step_cnt_q <= '0;
            vmrf_cnt_q <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= accept;
            if (accept) begin
                ready_q <= 1'b0;
            end else if (in_idle && !pending_q) begin
                ready_q <= 1'b1;    // One cycle after re-entering IDLE
            end
            step_cnt_q <= in_idle ? '0 : step_cnt_q + step_cnt_t'(1);
            if (in_idle) begin
                vmrf_cnt_q <= '0;
            end else if (wr_step) begin
                vmrf_cnt_q <= vmrf_cnt_q + vmrf_addr_t'(1);
            end
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (pending_q) begin
                    case (instr_q.inst_type)
                        NORMAL:  state_d = NORMAL_MODE;
                        STORE:   state_d = READ_MODE;
                        LOAD:    state_d = LOAD_MODE;
                        default: state_d = IDLE;
                    endcase
                end
            end
            NORMAL_MODE: if (last_write)  state_d = IDLE;   // After the last write step
            READ_MODE:   if (last_read)   state_d = IDLE;
            LOAD_MODE:   if (load_last_i) state_d = IDLE;
            default:     state_d = IDLE;
        endcase
    end

    // Counters and valid generator preload while idle
    assign raddr_load_o       = in_idle;
    assign waddr_load_o       = in_idle;
    assign valid_load_o       = in_idle;
    assign raddr_en_o         = (in_normal || in_read) && rd_active;
    assign valid_shift_o      = raddr_en_o;
    assign waddr_en_o         = wr_step || in_load;     // One word per load beat
    assign bwen_en_o          = wr_step;
    assign write_width_o      = in_load ? WIDTH_WORD : instr_q.wdata_width;
    assign store_data_valid_o = in_read && rd_active;
    assign ready_for_load_o   = in_load;
    assign load_mode_o        = in_load;
    assign vmrf_wen_o         = wr_step && instr_q.vector_mask;
    assign vmrf_addr_o        = vmrf_cnt_q;
    assign ready_o            = ready_q;
    assign instr_o            = instr_q;
    assign alu_o              = alu_q;

    a_type_legal : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        accept |-> (instr_i.inst_type inside {NORMAL, STORE, LOAD})
    );

endmodule

`default_nettype wire

//--- lane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module lane_sequencer (
    input  wire                                             clk_i,
    input  wire                                             rst_i,
    input  wire                                             start_i,
    output logic                                            ready_o,
    input  lane_seq_pkg::instr_t                            instr_i,
    input  lane_seq_pkg::alu_ctrl_t                         alu_i,
    input  lane_seq_pkg::lane_bwen_t                        load_bwen_i,
    input  wire                                             load_last_i,
    output lane_seq_pkg::alu_ctrl_t                         alu_o,
    output lane_seq_pkg::vrf_addr_t [lane_seq_pkg::RD_PORTS-1:0] vrf_raddr_o,
    output lane_seq_pkg::vrf_addr_t                         vrf_waddr_o,
    output lane_seq_pkg::lane_bwen_t                        vrf_bwen_o,
    output lane_seq_pkg::width_t                            vsew_o,
    output logic [lane_seq_pkg::LANES-1:0]                  read_data_valid_o,
    output lane_seq_pkg::vmrf_addr_t                        vmrf_addr_o,
    output logic                                            vmrf_wen_o,
    output logic                                            store_data_valid_o,
    output lane_seq_pkg::port_sel_t                         store_data_sel_o,
    output logic                                            ready_for_load_o,
    output logic                                            request_write_control_o
);
    import lane_seq_pkg::*;

    instr_t     instr;
    width_t     write_width;
    lane_bwen_t gen_bwen;
    logic       raddr_load, raddr_en;
    logic       waddr_load, waddr_en;
    logic       bwen_en, valid_load, valid_shift, load_mode;

    seq_ctrl i_ctrl (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .ready_o            (ready_o),
        .instr_i            (instr_i),
        .alu_i              (alu_i),
        .load_last_i        (load_last_i),
        .instr_o            (instr),
        .alu_o              (alu_o),
        .raddr_load_o       (raddr_load),
        .raddr_en_o         (raddr_en),
        .waddr_load_o       (waddr_load),
        .waddr_en_o         (waddr_en),
        .write_width_o      (write_width),
        .bwen_en_o          (bwen_en),
        .valid_load_o       (valid_load),
        .valid_shift_o      (valid_shift),
        .store_data_valid_o (store_data_valid_o),
        .ready_for_load_o   (ready_for_load_o),
        .load_mode_o        (load_mode),
        .vmrf_wen_o         (vmrf_wen_o),
        .vmrf_addr_o        (vmrf_addr_o)
    );

    ////////////////////////////////////////
    // Address counters
    ////////////////////////////////////////
    for (genvar p = 0; p < RD_PORTS; p++) begin : g_raddr
        vrf_addr_counter i_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .load_i       (raddr_load),
            .start_addr_i (instr.raddr_start[p]),
            .en_i         (raddr_en),
            .width_i      (instr.sew),      // Reads step by element width
            .addr_o       (vrf_raddr_o[p])
        );
    end

    vrf_addr_counter i_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (waddr_load),
        .start_addr_i (instr.waddr_start),
        .en_i         (waddr_en),
        .width_i      (write_width),
        .addr_o       (vrf_waddr_o)
    );

    bwen_gen i_bwen_gen (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .en_i    (bwen_en),
        .width_i (write_width),
        .bwen_o  (gen_bwen)
    );

    read_valid_gen i_read_valid (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (valid_load),
        .vl_i    (instr.vl),
        .shift_i (valid_shift),
        .valid_o (read_data_valid_o)
    );

    // Load beats carry their own byte enables
    assign vrf_bwen_o              = load_mode ? load_bwen_i : gen_bwen;
    assign request_write_control_o = load_mode;
    assign vsew_o                  = instr.sew;
    assign store_data_sel_o        = instr.store_data_sel;

endmodule

`default_nettype wire

//--- tb_lane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lane_sequencer;
    import lane_seq_pkg::*;

    // Worst-case instruction: 32 rows, delay 7, 16 load beats, handshake overhead
    localparam int RESET_CYCLES     = 8;
    localparam int MAX_INSTR_CYCLES = 32 + 7 + 16 + 8;
    localparam int N_INSTR          = 8;
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + N_INSTR * MAX_INSTR_CYCLES + 100;

    logic       clk_i;
    logic       rst_i;
    logic       start_i;
    logic       ready_o;
    instr_t     instr_i;
    alu_ctrl_t  alu_i;
    lane_bwen_t load_bwen_i;
    logic       load_last_i;
    alu_ctrl_t  alu_o;
    vrf_addr_t [RD_PORTS-1:0] vrf_raddr_o;
    vrf_addr_t  vrf_waddr_o;
    lane_bwen_t vrf_bwen_o;
    width_t     vsew_o;
    logic [LANES-1:0] read_data_valid_o;
    vmrf_addr_t vmrf_addr_o;
    logic       vmrf_wen_o;
    logic       store_data_valid_o;
    port_sel_t  store_data_sel_o;
    logic       ready_for_load_o;
    logic       request_write_control_o;

    logic [31:0] lfsr_state;
    int          err_cnt;
    int          check_cnt;
    int          test_cnt;
    int          cycle_cnt;

    lane_sequencer i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    // Byte enables of write step k, same on all lanes
    function automatic lane_bwen_t expected_bwen(input width_t wd, input int k);
        bwen_t lane;
        case (wd)
            WIDTH_BYTE: lane = bwen_t'(4'b0001 << (k % 4));
            WIDTH_HALF: lane = ((k % 2) == 0) ? 4'b0011 : 4'b1100;
            default:    lane = 4'b1111;
        endcase
        return {LANES{lane}};
    endfunction

    function automatic alu_ctrl_t random_alu();
        alu_ctrl_t a;
        a.op2_sel = 2'(rand_bits(2));
        a.op3_sel = port_sel_t'(rand_bits(3));
        a.x_data  = rand_bits(32);
        a.imm     = 5'(rand_bits(5));
        a.opmode  = 6'(rand_bits(6));
        return a;
    endfunction

    task automatic expect_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_cnt++;
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        $display("%s: finished with %0d errors", name, err_cnt - errs_before);
    endtask

    // Returns just after the accepting edge
    task automatic start_instr(input instr_t ins, input alu_ctrl_t alu);
        @(negedge clk_i);
        while (!ready_o) @(negedge clk_i);
        @(posedge clk_i);
        start_i <= 1'b1;
        instr_i <= ins;
        alu_i   <= alu;
        @(posedge clk_i);
        start_i <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic test_reset();
        int errs;
        errs = err_cnt;
        @(negedge clk_i);
        expect_val(32'(ready_o), 32'd1, "ready_o after reset");
        expect_val(vrf_bwen_o, 32'd0, "vrf_bwen_o after reset");
        expect_val(32'(vmrf_wen_o), 32'd0, "vmrf_wen_o after reset");
        expect_val(32'(store_data_valid_o), 32'd0, "store_data_valid_o after reset");
        expect_val(32'(ready_for_load_o), 32'd0, "ready_for_load_o after reset");
        expect_val(32'(request_write_control_o), 32'd0, "request_write_control_o after reset");
        expect_val(32'(read_data_valid_o), 32'd0, "read_data_valid_o after reset");
        report_test("reset", errs);
    endtask

    task automatic test_normal(input string name, input width_t wd, input logic mask);
        instr_t    ins;
        alu_ctrl_t alu;
        int        errs, vl, rl, k, n_wen, bytes, p;
        logic      prev_active;
        errs = err_cnt;
        ins  = '0;
        ins.inst_type   = NORMAL;
        vl              = int'(rand_bits(8)) + 1;
        rl              = (vl + LANES - 1) / LANES;
        ins.vl          = vl_t'(vl);
        ins.sew         = wd;
        ins.wdata_width = wd;
        ins.inst_delay  = lane_cnt_t'(rand_bits(3));
        ins.waddr_start = vrf_addr_t'(rand_bits(10));
        for (p = 0; p < RD_PORTS; p++) begin
            ins.raddr_start[p] = vrf_addr_t'(rand_bits(10));
        end
        ins.vector_mask = mask;
        alu   = random_alu();
        bytes = 1 << wd;
        k     = 0;
        n_wen = 0;
        prev_active = 1'b0;
        start_instr(ins, alu);
        @(negedge clk_i);
        expect_val(32'(ready_o), 32'd0, "ready_o after accept");
        while (!ready_o) begin
            expect_val(32'(alu_o), 32'(alu), "alu_o held");   // Low 32 bits
            expect_val(32'(alu_o >> 32), 32'(alu >> 32), "alu_o held upper");
            expect_val(32'(vsew_o), 32'(wd), "vsew_o");
            if (vrf_bwen_o != '0) begin
                expect_val(vrf_bwen_o, expected_bwen(wd, k), "vrf_bwen_o pattern");
                expect_val(32'(vrf_waddr_o),
                           32'(vrf_addr_t'(int'(ins.waddr_start) + (k * bytes) / 4)),
                           "vrf_waddr_o during write");
                k++;
                prev_active = 1'b1;
            end else if (prev_active) begin
                // First cycle after the window holds the final address
                expect_val(32'(vrf_waddr_o),
                           32'(vrf_addr_t'(int'(ins.waddr_start) + (rl * bytes) / 4)),
                           "vrf_waddr_o at end");
                prev_active = 1'b0;
            end
            if (vmrf_wen_o) begin
                // Mask writes go to consecutive addresses from zero
                expect_val(32'(vmrf_addr_o), 32'(n_wen), "vmrf_addr_o");
                n_wen++;
            end
            @(negedge clk_i);
        end
        expect_val(32'(k), 32'(rl), "write step count");
        expect_val(32'(n_wen), mask ? 32'(rl) : 32'd0, "vmrf_wen_o pulse count");
        report_test(name, errs);
    endtask

    task automatic test_store(input string name);
        instr_t    ins;
        alu_ctrl_t alu;
        int        errs, vl, rl, j, n_valid, n_runs, p;
        logic      prev_sdv;
        errs = err_cnt;
        ins  = '0;
        ins.inst_type      = STORE;
        vl                 = int'(rand_bits(8)) + 1;
        rl                 = (vl + LANES - 1) / LANES;
        ins.vl             = vl_t'(vl);
        ins.sew            = WIDTH_WORD;
        ins.wdata_width    = WIDTH_WORD;
        ins.store_data_sel = port_sel_t'(rand_bits(3));
        for (p = 0; p < RD_PORTS; p++) begin
            ins.raddr_start[p] = vrf_addr_t'(rand_bits(10));
        end
        alu      = random_alu();
        j        = 0;
        n_valid  = 0;
        n_runs   = 0;
        prev_sdv = 1'b0;
        start_instr(ins, alu);
        @(negedge clk_i);
        expect_val(32'(ready_o), 32'd0, "ready_o after accept");
        while (!ready_o) begin
            expect_val(32'(alu_o), 32'(alu), "alu_o held");
            expect_val(32'(store_data_sel_o), 32'(ins.store_data_sel), "store_data_sel_o");
            expect_val(32'(vsew_o), 32'(WIDTH_WORD), "vsew_o");
            if (store_data_valid_o) begin
                for (p = 0; p < RD_PORTS; p++) begin
                    expect_val(32'(vrf_raddr_o[p]),
                               32'(vrf_addr_t'(int'(ins.raddr_start[p]) + j)),
                               "vrf_raddr_o word step");
                end
                n_valid += $countones(read_data_valid_o);
                if (!prev_sdv) n_runs++;
                j++;
            end
            prev_sdv = store_data_valid_o;
            @(negedge clk_i);
        end
        expect_val(32'(j), 32'(rl), "store_data_valid_o cycles");
        expect_val(32'(n_runs), 32'd1, "store_data_valid_o consecutive");
        expect_val(32'(n_valid), 32'(vl), "read_data_valid_o total");
        report_test(name, errs);
    endtask

    task automatic test_load(input string name);
        instr_t     ins;
        alu_ctrl_t  alu;
        lane_bwen_t cur_bwen;
        int         errs, beats, b;
        errs = err_cnt;
        ins  = '0;
        ins.inst_type   = LOAD;
        ins.vl          = vl_t'(64);
        ins.wdata_width = WIDTH_BYTE;     // Load forces word stepping
        ins.waddr_start = vrf_addr_t'(rand_bits(10));
        beats    = int'(rand_bits(4)) + 1;
        alu      = random_alu();
        cur_bwen = rand_bits(32);
        start_instr(ins, alu);
        load_bwen_i <= cur_bwen;
        load_last_i <= (beats == 1);
        @(negedge clk_i);
        while (!ready_for_load_o) @(negedge clk_i);
        for (b = 0; b < beats; b++) begin
            expect_val(32'(ready_for_load_o), 32'd1, "ready_for_load_o in beat");
            expect_val(32'(request_write_control_o), 32'd1, "request_write_control_o in beat");
            expect_val(vrf_bwen_o, cur_bwen, "vrf_bwen_o mirrors load_bwen_i");
            expect_val(32'(vrf_waddr_o), 32'(vrf_addr_t'(int'(ins.waddr_start) + b)),
                       "vrf_waddr_o load beat");
            expect_val(32'(alu_o), 32'(alu), "alu_o held");
            @(posedge clk_i);
            if (b + 1 < beats) begin
                cur_bwen = rand_bits(32);
                load_bwen_i <= cur_bwen;
                load_last_i <= (b + 2 == beats);
            end else begin
                load_bwen_i <= '0;
                load_last_i <= 1'b0;
            end
            @(negedge clk_i);
        end
        expect_val(32'(ready_for_load_o), 32'd0, "ready_for_load_o after last beat");
        expect_val(32'(vrf_waddr_o), 32'(vrf_addr_t'(int'(ins.waddr_start) + beats)),
                   "vrf_waddr_o after load");
        while (!ready_o) @(negedge clk_i);
        report_test(name, errs);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        rst_i       = 1'b0;
        start_i     = 1'b0;
        instr_i     = '0;
        alu_i       = '0;
        load_bwen_i = '0;
        load_last_i = 1'b0;
        lfsr_state  = 32'h96d5;
        err_cnt     = 0;
        check_cnt   = 0;
        test_cnt    = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b1;

        test_reset();
        test_normal("normal_word_mask", WIDTH_WORD, 1'b1);
        test_normal("normal_word_nomask", WIDTH_WORD, 1'b0);
        test_normal("normal_byte", WIDTH_BYTE, 1'b1);
        test_normal("normal_half", WIDTH_HALF, 1'b0);
        test_store("store_a");
        test_store("store_b");
        test_load("load_a");
        test_load("load_b");

        $display("Tests: %0d  checks: %0d  errors: %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_cnt++;
        end
        $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
lane_seq_pkg.sv
vrf_addr_counter.sv
bwen_gen.sv
read_valid_gen.sv
seq_ctrl.sv
lane_sequencer.sv
tb_lane_sequencer.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the lane sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_lane_sequencer \
    --Mdir obj_dir -o tb_sim \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi
exit 0
